//--- logic/display_cmd_pkg.sv
package display_cmd_pkg;

	typedef enum logic [2:0] {
		OP_ACTIVE,
		OP_CLKEXT,
		OP_REG_WR,
		OP_DL_BUTTONS,
		OP_DL_FREQ,
		OP_DL_POWER,
		OP_DLSWAP,
		OP_TOUCH_RD
	} cmd_op_t;

	localparam int MAX_FRAME_BYTES = 12;
	localparam int FRAME_BITS = 8 * MAX_FRAME_BYTES;
	typedef logic [FRAME_BITS-1:0] frame_t; // First byte sent sits in the top bits
	typedef logic [3:0] frame_len_t; // Length in bytes

	localparam int SEQ_LEN = 10;
	localparam int SEQ_LOOP_START = 3; // Entries below this run once after reset
	typedef logic [3:0] seq_idx_t;

	localparam int SPI_HALF = 2; // clk20MHz cycles per SCLK phase
	typedef logic [$clog2(2*SPI_HALF)-1:0] spi_phase_t;
	typedef logic [$clog2(FRAME_BITS)-1:0] bit_cnt_t;

	localparam int GAP_CYCLES = 6; // cs_n high time between frames
	typedef logic [$clog2(GAP_CYCLES)-1:0] gap_cnt_t;

	localparam logic [23:0] TOUCH_ADDR = 24'h302124; // Read header for the touch register

	// Byte positions patched by the ROM, counted from the first byte sent
	localparam int DL_COLOUR_BYTE = 3;
	localparam int DL_FREQ_BYTE = 6;
	localparam int DL_POWER_BYTE = 7;

	localparam cmd_op_t CMD_TABLE [SEQ_LEN] = '{
		OP_ACTIVE, OP_CLKEXT, OP_REG_WR, // Init only
		OP_DL_BUTTONS, OP_DL_FREQ, OP_DL_POWER, OP_REG_WR, OP_DLSWAP,
		OP_TOUCH_RD, OP_TOUCH_RD
	};

	localparam frame_len_t CMD_LEN [SEQ_LEN] = '{
		4'd3, 4'd3, 4'd5,
		4'd8, 4'd8, 4'd8, 4'd5, 4'd4,
		4'd8, 4'd8
	};

	localparam frame_t CMD_BYTES [SEQ_LEN] = '{
		{24'h000000, 72'h0}, // Host ACTIVE
		{24'h614500, 72'h0}, // Host CLKEXT
		{40'hB0202CA003, 56'h0}, // HCYCLE
		{64'hB000F06464640450, 32'h0}, // Button colours and begin
		{64'hB00008FF00000021, 32'h0}, // Frequency button
		{64'hB00238FFFFFF0400, 32'h0}, // Power bar
		{40'hB020600100, 56'h0}, // DITHER
		{32'hB0205402, 64'h0}, // DLSWAP frame
		{TOUCH_ADDR, 40'h0, 32'h0},
		{TOUCH_ADDR, 40'h0, 32'h0}
	};

endpackage

//--- logic/touch_ui_pkg.sv
package touch_ui_pkg;

	typedef logic [15:0] coord_t;
	typedef logic [7:0] touch_tag_t;

	localparam touch_tag_t TOUCH_TAG = 8'h42;

	typedef enum logic [2:0] {
		ACT_NONE,
		ACT_RUN,
		ACT_OFF,
		ACT_SWEEP,
		ACT_LOCK,
		ACT_FREQ,
		ACT_POWER
	} ui_action_t;

	typedef logic [3:0] freq_sel_t; // 0 none, 1..11 for 30..40 kHz
	typedef logic [2:0] power_t; // 0..4 for 5..100 %

	// Command buttons in priority order
	localparam int NUM_CMD = 4;
	localparam ui_action_t CMD_ACT [NUM_CMD] = '{ACT_RUN, ACT_OFF, ACT_SWEEP, ACT_LOCK};
	localparam coord_t CMD_X_LO [NUM_CMD] = '{16'd84, 16'd75, 16'd75, 16'd75};
	localparam coord_t CMD_X_HI [NUM_CMD] = '{16'd210, 16'd210, 16'd210, 16'd210};
	localparam coord_t CMD_Y_LO [NUM_CMD] = '{16'd768, 16'd545, 16'd312, 16'd84};
	localparam coord_t CMD_Y_HI [NUM_CMD] = '{16'd871, 16'd643, 16'd415, 16'd187};

	// Frequency keys, one per kHz step
	localparam int NUM_FREQ = 11;
	localparam coord_t FREQ_X_LO [NUM_FREQ] = '{
		16'd311, 16'd372, 16'd432, 16'd492,
		16'd553, 16'd616, 16'd670, 16'd736,
		16'd791, 16'd848, 16'd909
	};
	localparam coord_t FREQ_X_HI [NUM_FREQ] = '{
		16'd348, 16'd412, 16'd468, 16'd523,
		16'd587, 16'd652, 16'd707, 16'd768,
		16'd816, 16'd880, 16'd940
	};
	localparam coord_t FREQ_Y_HI = 16'd730; // No lower Y bound on these keys

	// Power bar segments
	localparam int NUM_POWER = 5;
	localparam coord_t POWER_X_LO [NUM_POWER] = '{
		16'd488, 16'd620, 16'd718, 16'd802, 16'd887
	};
	localparam coord_t POWER_X_HI [NUM_POWER] = '{
		16'd568, 16'd681, 16'd781, 16'd860, 16'd947
	};
	localparam coord_t POWER_Y_LO = 16'd776;
	localparam coord_t POWER_Y_HI = 16'd895;

endpackage

//--- logic/spi_frame_shifter.sv
`timescale 1ns/1ps

module spi_frame_shifter import display_cmd_pkg::*; (
	input  logic        clk20MHz,
	input  logic        rst,
	input  logic        start,
	input  frame_t      frame,
	input  frame_len_t  len,
	input  logic        miso,
	output logic        sclk,
	output logic        mosi,
	output logic        cs_n,
	output logic        done,
	output logic [39:0] rx_data
);

	spi_phase_t ph; // Position inside one bit time
	bit_cnt_t   bit_cnt; // Bits left after the current one
	frame_t     shreg;

	// Phases 0..SPI_HALF-1 are SCLK low, the rest SCLK high
	always_ff @(posedge clk20MHz) begin
		if (rst) begin
			cs_n    <= 1'b1;
			sclk    <= 1'b0;
			mosi    <= 1'b0;
			done    <= 1'b0;
			ph      <= '0;
			bit_cnt <= '0;
		end else begin
			done <= 1'b0;
			if (cs_n) begin
				if (start) begin
					cs_n    <= 1'b0;
					ph      <= '0;
					mosi    <= frame[FRAME_BITS-1]; // First bit out with cs_n
					shreg   <= {frame[FRAME_BITS-2:0], 1'b0};
					bit_cnt <= bit_cnt_t'({len, 3'b000}) - 1'b1;
				end
			end else begin
				ph <= ph + 1'b1;
				if (ph == spi_phase_t'(SPI_HALF - 1)) begin
					sclk    <= 1'b1; // Rising edge takes the slave data
					rx_data <= {rx_data[38:0], miso};
				end
				if (ph == spi_phase_t'(2 * SPI_HALF - 1)) begin
					sclk <= 1'b0;
					ph   <= '0;
					if (bit_cnt == '0) begin
						cs_n <= 1'b1; // End of frame
						done <= 1'b1;
						mosi <= 1'b0;
					end else begin
						bit_cnt <= bit_cnt - 1'b1;
						mosi    <= shreg[FRAME_BITS-1];
						shreg   <= {shreg[FRAME_BITS-2:0], 1'b0};
					end
				end
			end
		end
	end

endmodule

//--- logic/display_list_rom.sv
`timescale 1ns/1ps

module display_list_rom import display_cmd_pkg::*, touch_ui_pkg::*; (
	input  seq_idx_t   idx,
	input  freq_sel_t  freq_sel,
	input  power_t     power_level,
	output frame_t     frame,
	output frame_len_t len
);

	seq_idx_t entry;
	cmd_op_t  op;

	// Out of range indexes fall back to the first entry
	assign entry = (idx < seq_idx_t'(SEQ_LEN)) ? idx : '0;
	assign op = CMD_TABLE[entry];

	always_comb begin
		frame = CMD_BYTES[entry];
		len = CMD_LEN[entry];
		case (op)
			OP_DL_FREQ: begin
				// Selected key is drawn dark, white when nothing is chosen
				frame[FRAME_BITS-1-8*DL_COLOUR_BYTE -: 8] = (freq_sel != '0) ? 8'h00 : 8'hFF;
				frame[FRAME_BITS-1-8*DL_FREQ_BYTE -: 8] = {4'h0, freq_sel}; // Marker 21 follows
			end
			OP_DL_POWER: begin
				frame[FRAME_BITS-1-8*DL_POWER_BYTE -: 8] = {5'b00000, power_level}; // Bar step
			end
			default: ; // Fixed bytes as stored
		endcase
	end

endmodule

//--- logic/display_list_sequencer.sv
`timescale 1ns/1ps

module display_list_sequencer import display_cmd_pkg::*; (
	input  logic     clk20MHz,
	input  logic     rst,
	input  logic     done,
	output seq_idx_t idx,
	output logic     start,
	output logic     touch_valid
);

	typedef enum logic [1:0] {
		SEQ_GAP,
		SEQ_START,
		SEQ_BUSY
	} seq_state_t;

	seq_state_t state;
	gap_cnt_t   gap_cnt;

	assign start = (state == SEQ_START);
	assign touch_valid = done && (CMD_TABLE[idx] == OP_TOUCH_RD); // idx still holds the read entry

	always_ff @(posedge clk20MHz) begin
		if (rst) begin
			state   <= SEQ_GAP;
			gap_cnt <= '0;
			idx     <= '0;
		end else begin
			case (state)
				SEQ_GAP: begin
					// Done cycle plus this wait plus the start cycle give GAP_CYCLES
					gap_cnt <= gap_cnt + 1'b1;
					if (gap_cnt == gap_cnt_t'(GAP_CYCLES - 3)) begin
						state <= SEQ_START;
					end
				end
				SEQ_START: begin
					state <= SEQ_BUSY;
				end
				SEQ_BUSY: begin
					if (done) begin
						state   <= SEQ_GAP;
						gap_cnt <= '0;
						if (idx == seq_idx_t'(SEQ_LEN - 1)) begin
							idx <= seq_idx_t'(SEQ_LOOP_START); // Skip init on the next lap
						end else begin
							idx <= idx + 1'b1;
						end
					end
				end
				default: begin
					state <= SEQ_GAP;
				end
			endcase
		end
	end

endmodule

//--- logic/touch_decoder.sv
`timescale 1ns/1ps

module touch_decoder import touch_ui_pkg::*; (
	input  logic        clk20MHz,
	input  logic        rst,
	input  logic        touch_valid,
	input  logic [39:0] rx_data,
	output logic        run,
	output logic        off,
	output logic        sweep,
	output logic        lock,
	output freq_sel_t   freq_sel,
	output power_t      power_level
);

	touch_tag_t tag;
	coord_t     x;
	coord_t     y;
	ui_action_t action;
	freq_sel_t  hit_freq;
	power_t     hit_power;

	// Controller sends each coordinate low byte first
	assign tag = rx_data[39:32];
	assign y = {rx_data[23:16], rx_data[31:24]};
	assign x = {rx_data[7:0], rx_data[15:8]};

	// Lowest priority first so the earliest region in the order wins
	always_comb begin
		action = ACT_NONE;
		hit_freq = '0;
		hit_power = '0;
		for (int i = NUM_POWER - 1; i >= 0; i--) begin
			if (x >= POWER_X_LO[i] && x <= POWER_X_HI[i] && y >= POWER_Y_LO && y <= POWER_Y_HI) begin
				action = ACT_POWER;
				hit_power = power_t'(i);
			end
		end
		for (int i = NUM_FREQ - 1; i >= 0; i--) begin
			if (x >= FREQ_X_LO[i] && x <= FREQ_X_HI[i] && y <= FREQ_Y_HI) begin
				action = ACT_FREQ;
				hit_freq = freq_sel_t'(i + 1); // Key 0 is 30 kHz
			end
		end
		for (int i = NUM_CMD - 1; i >= 0; i--) begin
			if (x >= CMD_X_LO[i] && x <= CMD_X_HI[i] && y >= CMD_Y_LO[i] && y <= CMD_Y_HI[i]) begin
				action = CMD_ACT[i];
			end
		end
		if (tag != TOUCH_TAG) begin
			action = ACT_NONE; // Reply without the touch tag
		end
	end

	always_ff @(posedge clk20MHz) begin
		if (rst) begin
			run         <= 1'b0;
			off         <= 1'b0;
			sweep       <= 1'b0;
			lock        <= 1'b0;
			freq_sel    <= '0;
			power_level <= '0;
		end else begin
			run   <= touch_valid && (action == ACT_RUN);
			off   <= touch_valid && (action == ACT_OFF);
			sweep <= touch_valid && (action == ACT_SWEEP);
			lock  <= touch_valid && (action == ACT_LOCK);
			if (touch_valid && action == ACT_FREQ) begin
				freq_sel <= hit_freq;
			end
			if (touch_valid && action == ACT_POWER) begin
				power_level <= hit_power;
			end
		end
	end

endmodule

//--- logic/display_top.sv
`timescale 1ns/1ps

module display_top import display_cmd_pkg::*, touch_ui_pkg::*; (
	input  logic      clk20MHz,
	input  logic      rst,
	input  logic      miso,
	output logic      sclk,
	output logic      mosi,
	output logic      cs_n,
	output logic      run,
	output logic      off,
	output logic      sweep,
	output logic      lock,
	output freq_sel_t freq_sel,
	output power_t    power_level
);

	seq_idx_t    idx;
	logic        start;
	logic        done;
	logic        touch_valid;
	frame_t      frame;
	frame_len_t  len;
	logic [39:0] rx_data; // Touch reply of the last frame

	display_list_sequencer display_list_sequencer_i (
		.clk20MHz    (clk20MHz),
		.rst         (rst),
		.done        (done),
		.idx         (idx),
		.start       (start),
		.touch_valid (touch_valid)
	);

	display_list_rom display_list_rom_i (
		.idx         (idx),
		.freq_sel    (freq_sel), // Selection fed back into the button colours
		.power_level (power_level),
		.frame       (frame),
		.len         (len)
	);

	spi_frame_shifter spi_frame_shifter_i (
		.clk20MHz (clk20MHz),
		.rst      (rst),
		.start    (start),
		.frame    (frame),
		.len      (len),
		.miso     (miso),
		.sclk     (sclk),
		.mosi     (mosi),
		.cs_n     (cs_n),
		.done     (done),
		.rx_data  (rx_data)
	);

	touch_decoder touch_decoder_i (
		.clk20MHz    (clk20MHz),
		.rst         (rst),
		.touch_valid (touch_valid),
		.rx_data     (rx_data),
		.run         (run),
		.off         (off),
		.sweep       (sweep),
		.lock        (lock),
		.freq_sel    (freq_sel),
		.power_level (power_level)
	);

endmodule

//--- test/display_top_props.sv
`timescale 1ns/1ps

module display_top_props import display_cmd_pkg::*; (
	input logic       clk20MHz,
	input logic       rst,
	input logic       start,
	input frame_len_t len,
	input logic       cs_n,
	input logic       sclk,
	input logic       run,
	input logic       off,
	input logic       sweep,
	input logic       lock
);

	logic [8:0] low_cnt; // Cycles with cs_n low in this frame
	frame_len_t held_len;
	int         fail_cnt = 0; // Assertion failures so far

	always_ff @(posedge clk20MHz) begin
		if (rst) begin
			low_cnt  <= '0;
			held_len <= '0;
		end else if (start && cs_n) begin
			low_cnt  <= '0;
			held_len <= len; // Length of the frame being sent
		end else if (!cs_n) begin
			low_cnt <= low_cnt + 1'b1;
		end
	end

	reset_idle: assert property (@(posedge clk20MHz) rst |=> cs_n && !sclk)
		else begin
			fail_cnt++;
			$error("cs_n or sclk active during reset");
		end

	frame_time: assert property (@(posedge clk20MHz) disable iff (rst)
		$rose(cs_n) |-> low_cnt == {held_len, 5'b00000})
		else begin
			fail_cnt++;
			$error("cs_n low time does not match the frame length");
		end

	one_pulse: assert property (@(posedge clk20MHz) disable iff (rst)
		$onehot0({run, off, sweep, lock}))
		else begin
			fail_cnt++;
			$error("more than one action pulse at once");
		end

endmodule

bind display_top display_top_props display_top_props_i (
	.clk20MHz (clk20MHz),
	.rst      (rst),
	.start    (start),
	.len      (len),
	.cs_n     (cs_n),
	.sclk     (sclk),
	.run      (run),
	.off      (off),
	.sweep    (sweep),
	.lock     (lock)
);

//--- test/display_top_tb.sv
`timescale 1ns/1ps

module display_top_tb import display_cmd_pkg::*, touch_ui_pkg::*; ();

	localparam int NUM_TESTS = 31;

	typedef struct packed {
		touch_tag_t tag;
		coord_t     y;
		coord_t     x;
	} touch_t;

	logic clk20MHz;
	logic rst;
	logic miso;
	logic sclk;
	logic mosi;
	logic cs_n;
	logic run;
	logic off;
	logic sweep;
	logic lock;
	freq_sel_t freq_sel;
	power_t power_level;

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int touches_sent = 0;
	int frames_checked = 0;
	int pulses_seen = 0;
	int pulses_expected = 0;
	int cycle_cnt = 0;
	logic [15:0] lfsr = 16'd62660;
	freq_sel_t exp_freq = '0; // UI state as the testbench predicts it
	power_t exp_power = '0;
	touch_t touch_q [$]; // Touches waiting for a read frame
	touch_t sent_q [$];
	frame_t got_q [$];
	int nbits_q [$];
	int idx_q [$];
	event frame_done;

	logic sclk_q = 1'b0;
	logic in_frame = 1'b0;
	frame_t reply = '0;
	frame_t shift_in = '0;
	int nbits = 0;
	int slave_idx = 0; // Table entry of the frame on the bus

	initial begin
		clk20MHz = 1'b0;
		forever #25 clk20MHz = ~clk20MHz;
	end

	display_top display_top_i (
		.clk20MHz    (clk20MHz),
		.rst         (rst),
		.miso        (miso),
		.sclk        (sclk),
		.mosi        (mosi),
		.cs_n        (cs_n),
		.run         (run),
		.off         (off),
		.sweep       (sweep),
		.lock        (lock),
		.freq_sel    (freq_sel),
		.power_level (power_level)
	);

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic touch_t make_touch(input touch_tag_t tag, input coord_t x, input coord_t y);
		touch_t t;
		t.tag = tag;
		t.x = x;
		t.y = y;
		return t;
	endfunction

	function automatic coord_t region_mid(input coord_t lo, input coord_t hi);
		return (lo + hi) / 2;
	endfunction

	// First region in priority order wins
	function automatic ui_action_t predict_action(input touch_t t, output freq_sel_t f,
			output power_t p);
		f = '0;
		p = '0;
		if (t.tag != TOUCH_TAG) return ACT_NONE;
		for (int i = 0; i < NUM_CMD; i++) begin
			if (t.x >= CMD_X_LO[i] && t.x <= CMD_X_HI[i] &&
					t.y >= CMD_Y_LO[i] && t.y <= CMD_Y_HI[i])
				return CMD_ACT[i];
		end
		for (int i = 0; i < NUM_FREQ; i++) begin
			if (t.x >= FREQ_X_LO[i] && t.x <= FREQ_X_HI[i] && t.y <= FREQ_Y_HI) begin
				f = freq_sel_t'(i + 1);
				return ACT_FREQ;
			end
		end
		for (int i = 0; i < NUM_POWER; i++) begin
			if (t.x >= POWER_X_LO[i] && t.x <= POWER_X_HI[i] &&
					t.y >= POWER_Y_LO && t.y <= POWER_Y_HI) begin
				p = power_t'(i);
				return ACT_POWER;
			end
		end
		return ACT_NONE;
	endfunction

	function automatic frame_t build_frame(input int entry, input freq_sel_t f, input power_t p);
		frame_t fr;
		int last;
		fr = CMD_BYTES[entry];
		last = FRAME_BITS - 8 * CMD_LEN[entry]; // Bit offset of the final byte
		if (CMD_TABLE[entry] == OP_DL_FREQ) begin
			fr[FRAME_BITS-1-8*DL_COLOUR_BYTE -: 8] = (f != '0) ? 8'h00 : 8'hFF;
			fr[last+8 +: 8] = 8'(f);
			fr[last +: 8] = 8'h21;
		end
		if (CMD_TABLE[entry] == OP_DL_POWER) fr[last +: 8] = 8'(p);
		return fr;
	endfunction

	function automatic ui_action_t pulse_action();
		case ({run, off, sweep, lock})
			4'b1000: return ACT_RUN;
			4'b0100: return ACT_OFF;
			4'b0010: return ACT_SWEEP;
			4'b0001: return ACT_LOCK;
			4'b0000: return ACT_NONE;
			default: return ui_action_t'(3'd7); // Several pulses at once
		endcase
	endfunction

	task automatic compare_frame(input int entry, input frame_t got, input int nb,
			input frame_t exp);
		checks++;
		if (nb != 8 * CMD_LEN[entry]) begin
			errors++;
			$display("Fail cs_n bit count entry %0d got %h expected %h", entry, nb,
				8 * CMD_LEN[entry]);
		end else if (got !== exp) begin
			errors++;
			$display("Fail mosi entry %0d got %h expected %h", entry, got, exp);
		end
	endtask

	task automatic check_action(input ui_action_t got, input ui_action_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail run/off/sweep/lock got %h expected %h", got, exp);
		end
	endtask

	task automatic freq_match(input freq_sel_t got, input freq_sel_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail freq_sel got %h expected %h", got, exp);
		end
	endtask

	task automatic power_match(input power_t got, input power_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail power_level got %h expected %h", got, exp);
		end
	endtask

	task automatic level_check(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s got %h expected %h", name, got, exp);
		end
	endtask

	// SPI slave taking MOSI on each SCLK rise and setting up MISO for the next rise
	always @(negedge clk20MHz) begin
		touch_t t;
		if (rst || cs_n) begin
			if (in_frame) begin
				got_q.push_back(shift_in << (FRAME_BITS - nbits));
				nbits_q.push_back(nbits);
				idx_q.push_back(slave_idx);
				slave_idx = (slave_idx == SEQ_LEN - 1) ? SEQ_LOOP_START : slave_idx + 1;
				in_frame = 1'b0;
				-> frame_done;
			end
			nbits = 0;
			shift_in = '0;
			reply = '0;
		end else if (!in_frame) begin
			in_frame = 1'b1;
			if (CMD_TABLE[slave_idx] == OP_TOUCH_RD) begin
				t = '0; // Idle reply without a finger down
				if (touch_q.size() > 0) begin
					t = touch_q.pop_front();
					touches_sent++;
				end
				sent_q.push_back(t);
				reply = {24'h0, t.tag, t.y[7:0], t.y[15:8], t.x[7:0], t.x[15:8], 32'h0};
			end
		end else if (sclk && !sclk_q) begin
			shift_in = {shift_in[FRAME_BITS-2:0], mosi};
			nbits++;
		end
		miso <= (nbits < FRAME_BITS) ? reply[FRAME_BITS-1-nbits] : 1'b0;
		sclk_q = sclk;
	end

	always @(negedge clk20MHz) begin
		if (!rst && pulse_action() != ACT_NONE) pulses_seen++;
	end

	initial begin
		int entry;
		touch_t t;
		ui_action_t act;
		freq_sel_t f;
		power_t p;
		forever begin
			@(frame_done);
			entry = idx_q.pop_front();
			compare_frame(entry, got_q.pop_front(), nbits_q.pop_front(),
				build_frame(entry, exp_freq, exp_power));
			if (CMD_TABLE[entry] == OP_TOUCH_RD) begin
				t = sent_q.pop_front();
				act = predict_action(t, f, p);
				if (act == ACT_FREQ) exp_freq = f;
				if (act == ACT_POWER) exp_power = p;
				if (act == ACT_FREQ || act == ACT_POWER) act = ACT_NONE; // No pulse for these
				if (act != ACT_NONE) pulses_expected++;
				@(negedge clk20MHz); // Decoder answers one cycle after done
				check_action(pulse_action(), act);
				freq_match(freq_sel, exp_freq);
				power_match(power_level, exp_power);
			end
			frames_checked++;
		end
	end

	// One touch, then a full lap so the next DL_FREQ and DL_POWER frames are seen
	task automatic run_touch(input string name, input touch_t t);
		int err_before;
		int target;
		int frames_before;
		err_before = errors;
		target = touches_sent + 1;
		touch_q.push_back(t);
		wait (touches_sent == target);
		frames_before = frames_checked;
		wait (frames_checked >= frames_before + SEQ_LEN - SEQ_LOOP_START);
		tests++;
		$display("Test %0d %s x=%0d y=%0d tag=%h %s", tests, name, t.x, t.y, t.tag,
			(errors == err_before) ? "ok" : "mismatch");
	endtask

	initial begin
		logic [15:0] rx;
		logic [15:0] ry;
		logic [15:0] rt;
		rst = 1'b1;
		miso = 1'b0;
		repeat (4) @(negedge clk20MHz);
		level_check("cs_n", cs_n, 1'b1);
		level_check("sclk", sclk, 1'b0);
		level_check("mosi", mosi, 1'b0);
		check_action(pulse_action(), ACT_NONE);
		freq_match(freq_sel, '0);
		power_match(power_level, '0);
		rst = 1'b0;
		for (int k = 0; k < NUM_CMD; k++) begin
			run_touch("command", make_touch(TOUCH_TAG, region_mid(CMD_X_LO[k], CMD_X_HI[k]),
				region_mid(CMD_Y_LO[k], CMD_Y_HI[k])));
		end
		for (int k = 0; k < NUM_FREQ; k++) begin
			run_touch("freq", make_touch(TOUCH_TAG, region_mid(FREQ_X_LO[k], FREQ_X_HI[k]),
				FREQ_Y_HI / 2));
		end
		for (int k = 0; k < NUM_POWER; k++) begin
			run_touch("power", make_touch(TOUCH_TAG, region_mid(POWER_X_LO[k], POWER_X_HI[k]),
				region_mid(POWER_Y_LO, POWER_Y_HI)));
		end
		for (int k = 0; k < 8; k++) begin
			take_bits(10, rx);
			take_bits(10, ry);
			run_touch("random", make_touch(TOUCH_TAG, rx, ry));
		end
		for (int k = 0; k < 3; k++) begin
			take_bits(8, rt);
			if (rt[7:0] == TOUCH_TAG) rt[0] = ~rt[0];
			run_touch("bad_tag", make_touch(rt[7:0], region_mid(FREQ_X_LO[k], FREQ_X_HI[k]),
				16'd300));
		end
		if (pulses_seen != pulses_expected) begin
			errors++;
			$display("Fail action pulse count got %h expected %h", pulses_seen, pulses_expected);
		end
		if (display_top_i.display_top_props_i.fail_cnt != 0) begin
			errors++;
			$display("Bound assertions failed %0d times",
				display_top_i.display_top_props_i.fail_cnt);
		end
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		int limit;
		limit = 0;
		for (int i = 0; i < SEQ_LEN; i++) begin
			limit += 32 * CMD_LEN[i] + GAP_CYCLES; // Cycles of one table lap
		end
		limit = 2 * limit * NUM_TESTS;
		while (cycle_cnt < limit) begin
			@(posedge clk20MHz);
			cycle_cnt++;
		end
		$display("Timeout, the tests did not finish within %0d clock cycles", limit);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- vlog.f
logic/display_cmd_pkg.sv
logic/touch_ui_pkg.sv
logic/spi_frame_shifter.sv
logic/display_list_rom.sv
logic/display_list_sequencer.sv
logic/touch_decoder.sv
logic/display_top.sv
test/display_top_props.sv
test/display_top_tb.sv

//--- Bender.yml
package:
  name: display_top

sources:
  - logic/display_cmd_pkg.sv
  - logic/touch_ui_pkg.sv
  - logic/spi_frame_shifter.sv
  - logic/display_list_rom.sv
  - logic/display_list_sequencer.sv
  - logic/touch_decoder.sv
  - logic/display_top.sv
  - target: test
    files:
      - test/display_top_props.sv
      - test/display_top_tb.sv
